/* design/rx_types_pkg.sv */
package rx_types_pkg;

  localparam int BEAT_W           = 32;
  localparam int BEATS_PER_PACKET = 8;
  localparam int DATA_BEATS       = 3;
  localparam int COUNT_W          = 8;

  // one stream beat as it crosses the link
  typedef struct packed {
    logic [BEAT_W-1:0] data;
    logic [1:0]        empty;    // carried only, every beat is full
    logic              sop;
    logic              eop;
  } beat_t;

  typedef struct packed {
    logic [31:0] hw_addr;        // whole first address beat
    logic [15:0] sw_addr;        // second beat bits 31:16
    logic [6:0]  port;           // second beat bits 15:9
    logic        flag;           // broadcast marker, bit 8
  } node_addr_t;

  // field order follows the beat order on the wire
  typedef struct packed {
    node_addr_t                   dest_addr;
    node_addr_t                   src_addr;
    logic [BEAT_W-1:0]            lamport;
    logic [DATA_BEATS*BEAT_W-1:0] data;     // first data beat in the low word
  } packet_t;

  typedef logic [COUNT_W-1:0] count_t;

  typedef logic [$clog2(BEATS_PER_PACKET)-1:0] beat_idx_t;

  localparam count_t COUNT_MAX = '1;

  // event counter that sticks at its top value
  function automatic count_t count_inc(input count_t c);
    return (c == COUNT_MAX) ? c : count_t'(c + 1'b1);
  endfunction

endpackage

/* design/credit_queue.sv */
`timescale 1ns/1ns

module credit_queue #(
  parameter type item_t      = logic [31:0],
  parameter int  DEPTH       = 4,
  parameter int  OUT_CREDITS = 2
) (
  input  logic  clk,
  input  logic  reset_n,
  input  item_t in_item,
  input  logic  in_valid,
  output logic  in_credit,
  output item_t out_item,
  output logic  out_valid,
  input  logic  out_credit
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam int CRD_W = $clog2(OUT_CREDITS + 1);

  item_t            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] fill;       // items held
  logic [CRD_W-1:0] credits;    // downstream slots we may use

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  // head leaves whenever there is one and the receiver has room
  assign out_valid = (fill != '0) && (credits != '0);
  assign out_item  = mem[rd_ptr];

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      fill      <= '0;
      credits   <= CRD_W'(OUT_CREDITS);
      in_credit <= 1'b0;
    end else begin
      if (in_valid) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (out_valid) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      fill      <= fill + CNT_W'(in_valid) - CNT_W'(out_valid);
      credits   <= credits + CRD_W'(out_credit) - CRD_W'(out_valid);
      in_credit <= out_valid;  // slot freed last cycle
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      mem[wr_ptr] <= in_item;
    end
  end

  // a sender that honours its credits never writes into a full buffer
  a_no_overflow: assert property (@(posedge clk) disable iff (!reset_n)
    in_valid |-> (fill != CNT_W'(DEPTH)));

  // receiver must not hand back more slots than it has
  a_credit_bound: assert property (@(posedge clk) disable iff (!reset_n)
    credits <= CRD_W'(OUT_CREDITS));

endmodule

/* design/packet_deframer.sv */
`timescale 1ns/1ns

module packet_deframer (
  input  logic                  clk,
  input  logic                  reset_n,
  input  rx_types_pkg::beat_t   beat,
  input  logic                  beat_valid,
  output logic                  beat_credit,
  output rx_types_pkg::packet_t pkt,
  output logic                  pkt_valid,
  input  logic                  pkt_credit,
  output rx_types_pkg::count_t  frame_errors
);

  localparam rx_types_pkg::beat_idx_t LAST_IDX =
    rx_types_pkg::beat_idx_t'(rx_types_pkg::BEATS_PER_PACKET - 1);

  rx_types_pkg::beat_t     hold_beat;   // parked while a packet waits
  logic                    hold_valid;
  rx_types_pkg::beat_t     cur;
  logic                    cur_valid;
  logic                    consume;
  rx_types_pkg::beat_idx_t idx;         // next beat position
  rx_types_pkg::beat_idx_t field_idx;
  logic                    hunting;     // skipping to the next sop
  logic                    pkt_done;
  logic                    has_credit;
  logic                    sop_err;
  logic                    eop_err;
  logic                    frame_err;
  logic                    load;
  rx_types_pkg::packet_t   pkt_q;

  assign cur       = hold_valid ? hold_beat : beat;
  assign cur_valid = hold_valid | beat_valid;
  assign consume   = cur_valid & ~pkt_done;

  // sop only on the first beat, and a packet must open with one
  assign sop_err   = cur.sop ? (idx != '0) : ((idx == '0) && !hunting);
  assign eop_err   = cur.sop ? cur.eop
                             : (!hunting && (idx != '0) && (cur.eop != (idx == LAST_IDX)));
  assign frame_err = consume & (sop_err | eop_err);

  // a clean sop always opens a new packet, even after a broken one
  assign load      = consume & ((cur.sop & ~cur.eop) | (~hunting & ~frame_err));
  assign field_idx = cur.sop ? '0 : idx;

  assign pkt_valid = pkt_done & has_credit;
  assign pkt       = pkt_q;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      idx          <= '0;
      hunting      <= 1'b0;
      pkt_done     <= 1'b0;
      hold_valid   <= 1'b0;
      has_credit   <= 1'b1;  // filter register starts empty
      beat_credit  <= 1'b0;
      frame_errors <= '0;
    end else begin
      if (load) begin
        hunting  <= 1'b0;
        pkt_done <= (field_idx == LAST_IDX);
        idx      <= (field_idx == LAST_IDX) ? '0 : field_idx + 1'b1;
      end else if (frame_err) begin
        hunting <= 1'b1;   // drop the partial packet
        idx     <= '0;
      end else if (pkt_valid) begin
        pkt_done <= 1'b0;
      end
      if (beat_valid && pkt_done) begin
        hold_valid <= 1'b1;
      end else if (consume) begin
        hold_valid <= 1'b0;
      end
      if (pkt_credit) begin
        has_credit <= 1'b1;
      end else if (pkt_valid) begin
        has_credit <= 1'b0;
      end
      beat_credit <= consume;
      if (frame_err) begin
        frame_errors <= rx_types_pkg::count_inc(frame_errors);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (beat_valid && pkt_done) begin
      hold_beat <= beat;
    end
    if (load) begin
      case (field_idx)
        3'd0:    pkt_q.dest_addr.hw_addr <= cur.data;
        3'd1:    {pkt_q.dest_addr.sw_addr, pkt_q.dest_addr.port,
                  pkt_q.dest_addr.flag} <= cur.data[31:8];
        3'd2:    pkt_q.src_addr.hw_addr <= cur.data;
        3'd3:    {pkt_q.src_addr.sw_addr, pkt_q.src_addr.port,
                  pkt_q.src_addr.flag} <= cur.data[31:8];
        3'd4:    pkt_q.lamport <= cur.data;
        3'd5:    pkt_q.data[31:0] <= cur.data;
        3'd6:    pkt_q.data[63:32] <= cur.data;
        default: pkt_q.data[95:64] <= cur.data;
      endcase
    end
  end

  // the beat queue holds a single credit, so at most one beat is in flight
  a_one_beat: assert property (@(posedge clk) disable iff (!reset_n)
    beat_valid |-> !hold_valid);

  // the filter hands its one slot back only after we used it
  a_pkt_credit: assert property (@(posedge clk) disable iff (!reset_n)
    pkt_credit |-> !has_credit);

endmodule

/* design/dest_filter.sv */
`timescale 1ns/1ns

module dest_filter #(
  parameter logic [31:0] NODE_HW_ADDR = 32'h0,
  parameter int          PKT_DEPTH    = 2
) (
  input  logic                  clk,
  input  logic                  reset_n,
  input  rx_types_pkg::packet_t in_pkt,
  input  logic                  in_valid,
  output logic                  in_credit,
  output rx_types_pkg::packet_t out_pkt,
  output logic                  out_valid,
  input  logic                  out_credit,
  output rx_types_pkg::count_t  drops
);

  localparam int CRD_W = $clog2(PKT_DEPTH + 1);

  rx_types_pkg::packet_t pkt_q;
  logic                  full;      // register holds an accepted packet
  logic                  accept;
  logic                  drop;
  logic [CRD_W-1:0]      credits;   // free slots in the packet queue

  // ours or broadcast
  assign accept = (in_pkt.dest_addr.hw_addr == NODE_HW_ADDR) || in_pkt.dest_addr.flag;
  assign drop   = in_valid & ~accept;

  assign out_valid = full && (credits != '0);
  assign out_pkt   = pkt_q;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      full      <= 1'b0;
      credits   <= CRD_W'(PKT_DEPTH);
      in_credit <= 1'b0;
      drops     <= '0;
    end else begin
      if (in_valid && accept) begin
        full <= 1'b1;
      end else if (out_valid) begin
        full <= 1'b0;
      end
      credits   <= credits + CRD_W'(out_credit) - CRD_W'(out_valid);
      in_credit <= drop | out_valid;  // register free again
      if (drop) begin
        drops <= rx_types_pkg::count_inc(drops);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && accept) begin
      pkt_q <= in_pkt;
    end
  end

  // deframer only sends after we returned the single register slot
  a_no_overwrite: assert property (@(posedge clk) disable iff (!reset_n)
    in_valid |-> !full);

endmodule

/* design/packet_rx_top.sv */
`timescale 1ns/1ns

module packet_rx_top #(
  parameter logic [31:0] NODE_HW_ADDR = 32'h0000_00A5,
  parameter int          BEAT_DEPTH   = 8,
  parameter int          PKT_DEPTH    = 2,
  parameter int          OUT_CREDITS  = 2
) (
  input  logic                  clk,
  input  logic                  reset_n,
  input  rx_types_pkg::beat_t   in_beat,
  input  logic                  in_valid,
  output logic                  in_credit,
  output rx_types_pkg::packet_t out_pkt,
  output logic                  out_valid,
  input  logic                  out_credit,
  output rx_types_pkg::count_t  frame_errors,
  output rx_types_pkg::count_t  drops
);

  localparam int DEFRAMER_SLOTS = 1;  // one-beat holding register

  rx_types_pkg::beat_t   q_beat;
  logic                  q_beat_valid;
  logic                  q_beat_credit;
  rx_types_pkg::packet_t fr_pkt;
  logic                  fr_pkt_valid;
  logic                  fr_pkt_credit;
  rx_types_pkg::packet_t flt_pkt;
  logic                  flt_pkt_valid;
  logic                  flt_pkt_credit;

  credit_queue #(
    .item_t      (rx_types_pkg::beat_t),
    .DEPTH       (BEAT_DEPTH),
    .OUT_CREDITS (DEFRAMER_SLOTS)
  ) beat_queue (
    .clk        (clk),
    .reset_n    (reset_n),
    .in_item    (in_beat),
    .in_valid   (in_valid),
    .in_credit  (in_credit),
    .out_item   (q_beat),
    .out_valid  (q_beat_valid),
    .out_credit (q_beat_credit)
  );

  packet_deframer deframer (
    .clk          (clk),
    .reset_n      (reset_n),
    .beat         (q_beat),
    .beat_valid   (q_beat_valid),
    .beat_credit  (q_beat_credit),
    .pkt          (fr_pkt),
    .pkt_valid    (fr_pkt_valid),
    .pkt_credit   (fr_pkt_credit),
    .frame_errors (frame_errors)
  );

  dest_filter #(
    .NODE_HW_ADDR (NODE_HW_ADDR),
    .PKT_DEPTH    (PKT_DEPTH)
  ) filter (
    .clk        (clk),
    .reset_n    (reset_n),
    .in_pkt     (fr_pkt),
    .in_valid   (fr_pkt_valid),
    .in_credit  (fr_pkt_credit),
    .out_pkt    (flt_pkt),
    .out_valid  (flt_pkt_valid),
    .out_credit (flt_pkt_credit),
    .drops      (drops)
  );

  credit_queue #(
    .item_t      (rx_types_pkg::packet_t),
    .DEPTH       (PKT_DEPTH),
    .OUT_CREDITS (OUT_CREDITS)
  ) pkt_queue (
    .clk        (clk),
    .reset_n    (reset_n),
    .in_item    (flt_pkt),
    .in_valid   (flt_pkt_valid),
    .in_credit  (flt_pkt_credit),
    .out_item   (out_pkt),
    .out_valid  (out_valid),
    .out_credit (out_credit)
  );

endmodule

/* bench/packet_rx_cases.svh */
`ifndef PACKET_RX_CASES_SVH
`define PACKET_RX_CASES_SVH

typedef enum logic [1:0] {
  CORRUPT_NONE,
  CORRUPT_NO_SOP,      // first beat without sop
  CORRUPT_EARLY_EOP,   // eop on a middle beat
  CORRUPT_NO_EOP       // eighth beat without eop
} corrupt_t;

typedef enum logic [1:0] {DELIVERED, DROPPED, FRAME_ERROR} outcome_t;

typedef struct packed {
  logic [31:0] dest_hw;
  logic [31:0] dest_w1;   // sw_addr 31:16, port 15:9, broadcast flag 8
  logic [31:0] src_hw;
  logic [31:0] src_w1;
  logic [31:0] lamport;
  corrupt_t    corrupt;
  outcome_t    outcome;
} case_t;

localparam int NUM_CASES = 14;

// dest_hw, dest_w1, src_hw, src_w1, lamport, corruption, expected outcome
localparam case_t CASES [NUM_CASES] = '{
  '{32'h0000_00A5, 32'h0010_025A, 32'h11, 32'h0020_0400, 32'h1, CORRUPT_NONE, DELIVERED},
  '{32'h0000_0033, 32'h0010_0200, 32'h12, 32'h0021_0400, 32'h2, CORRUPT_NONE, DROPPED},
  '{32'h0000_0044, 32'hFFFF_FF00, 32'h13, 32'h0022_0600, 32'h3, CORRUPT_NONE, DELIVERED},
  '{32'h0000_00A5, 32'h0010_0200, 32'h14, 32'h0023_0400, 32'h4, CORRUPT_NO_SOP, FRAME_ERROR},
  '{32'h0000_00A5, 32'h0011_0400, 32'h15, 32'h0024_0200, 32'h5, CORRUPT_NONE, DELIVERED},
  '{32'h0000_00A5, 32'h0012_0200, 32'h16, 32'h0025_0400, 32'h6, CORRUPT_EARLY_EOP, FRAME_ERROR},
  '{32'h1234_5678, 32'h0013_0101, 32'h17, 32'h0026_0400, 32'h7, CORRUPT_NONE, DELIVERED},
  '{32'h0000_0055, 32'h0014_0200, 32'h18, 32'h0027_0400, 32'h8, CORRUPT_NO_EOP, FRAME_ERROR},
  '{32'h0000_00A5, 32'h0015_0600, 32'h19, 32'h0028_0400, 32'h9, CORRUPT_NONE, DELIVERED},
  '{32'h0000_0066, 32'h0016_0200, 32'h1A, 32'h0029_0400, 32'hA, CORRUPT_NONE, DROPPED},
  '{32'h0000_00A5, 32'h0017_0200, 32'h1B, 32'h002A_0400, 32'hB, CORRUPT_NONE, DELIVERED},
  '{32'h0000_0077, 32'h0018_0100, 32'h1C, 32'h002B_0400, 32'hC, CORRUPT_NONE, DELIVERED},
  '{32'h0000_00A5, 32'h0019_FE00, 32'h1D, 32'h002C_0400, 32'hD, CORRUPT_NONE, DELIVERED},
  '{32'h0000_0099, 32'h001A_0200, 32'h1E, 32'h002D_0400, 32'hE, CORRUPT_NONE, DROPPED}
};

`endif

/* bench/packet_rx_tb.sv */
`timescale 1ns/1ns

module packet_rx_tb;

  localparam logic [31:0] NODE_HW_ADDR = 32'h0000_00A5;
  localparam int BEAT_DEPTH     = 8;
  localparam int PKT_DEPTH      = 2;
  localparam int OUT_CREDITS    = 2;
  localparam int STALL_AFTER    = 2;    // packets seen before the long stall
  localparam int STALL_CYCLES   = 300;
  localparam int SETTLE_CYCLES  = 4;    // deframer and filter after the last beat
  localparam int EARLY_EOP_BEAT = 4;

  `include "packet_rx_cases.svh"

  localparam int TIMEOUT_CYCLES = NUM_CASES * rx_types_pkg::BEATS_PER_PACKET * 40;

  logic                  clk = 1'b0;
  logic                  reset_n;
  rx_types_pkg::beat_t   in_beat;
  logic                  in_valid;
  logic                  in_credit;
  rx_types_pkg::packet_t out_pkt;
  logic                  out_valid;
  logic                  out_credit;
  rx_types_pkg::count_t  frame_errors;
  rx_types_pkg::count_t  drops;

  integer                seed = 1472;
  int                    tx_credits = BEAT_DEPTH;
  int                    cons_credits = OUT_CREDITS;  // consumer slots the DUT may use
  int                    rx_count = 0;
  int                    owed = 0;      // credits the consumer still has to return
  int                    cycles = 0;
  logic                  stalled = 1'b0;
  rx_types_pkg::packet_t exp_q [$];

  packet_rx_top #(
    .NODE_HW_ADDR (NODE_HW_ADDR),
    .BEAT_DEPTH   (BEAT_DEPTH),
    .PKT_DEPTH    (PKT_DEPTH),
    .OUT_CREDITS  (OUT_CREDITS)
  ) UUT (
    .clk          (clk),
    .reset_n      (reset_n),
    .in_beat      (in_beat),
    .in_valid     (in_valid),
    .in_credit    (in_credit),
    .out_pkt      (out_pkt),
    .out_valid    (out_valid),
    .out_credit   (out_credit),
    .frame_errors (frame_errors),
    .drops        (drops)
  );

  always #50 clk = ~clk;

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_packet(input rx_types_pkg::packet_t got, input rx_types_pkg::packet_t exp);
    if (got !== exp) begin
      abort_run($sformatf("MISMATCH at %0t ns: packet %0d got %h expected %h",
                          $time, rx_count, got, exp));
    end
  endtask

  task automatic check_count(input string name, input rx_types_pkg::count_t got,
                             input rx_types_pkg::count_t exp);
    if (got !== exp) begin
      abort_run($sformatf("MISMATCH at %0t ns: %s got %0d expected %0d", $time, name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("MISMATCH at %0t ns: %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  // waits for a sender credit, then drives one beat
  task automatic send_beat(input rx_types_pkg::beat_t b);
    @(posedge clk);
    #1;
    while (tx_credits == 0) begin
      in_valid = 1'b0;
      @(posedge clk);
      #1;
    end
    in_beat    = b;
    in_valid   = 1'b1;
    tx_credits = tx_credits - 1;
  endtask

  task automatic send_case(input case_t c);
    logic [31:0]           words [rx_types_pkg::BEATS_PER_PACKET];
    rx_types_pkg::beat_t   b;
    rx_types_pkg::packet_t exp;
    words[0] = c.dest_hw;
    words[1] = c.dest_w1;
    words[2] = c.src_hw;
    words[3] = c.src_w1;
    words[4] = c.lamport;
    for (int i = 5; i < rx_types_pkg::BEATS_PER_PACKET; i++) begin
      words[i] = $random(seed);
    end
    if (c.outcome == DELIVERED) begin
      exp.dest_addr.hw_addr = c.dest_hw;
      {exp.dest_addr.sw_addr, exp.dest_addr.port, exp.dest_addr.flag} = c.dest_w1[31:8];
      exp.src_addr.hw_addr = c.src_hw;
      {exp.src_addr.sw_addr, exp.src_addr.port, exp.src_addr.flag} = c.src_w1[31:8];
      exp.lamport = c.lamport;
      exp.data    = {words[7], words[6], words[5]};  // first data beat lowest
      exp_q.push_back(exp);
    end
    for (int i = 0; i < rx_types_pkg::BEATS_PER_PACKET; i++) begin
      b.data  = words[i];
      b.empty = 2'b00;
      b.sop   = (i == 0) && (c.corrupt != CORRUPT_NO_SOP);
      b.eop   = (i == rx_types_pkg::BEATS_PER_PACKET - 1) ? (c.corrupt != CORRUPT_NO_EOP)
                                                          : (c.corrupt == CORRUPT_EARLY_EOP &&
                                                             i == EARLY_EOP_BEAT);
      send_beat(b);
    end
  endtask

  // scoreboard and credit bookkeeping on both outer edges
  always @(posedge clk) begin
    if (reset_n === 1'b1) begin
      if (out_valid) begin
        if (cons_credits == 0) abort_run("out_valid came while the consumer had no credit out");
        if (exp_q.size() == 0) abort_run("a packet came out that was never expected");
        check_packet(out_pkt, exp_q.pop_front());
        rx_count = rx_count + 1;
        owed     = owed + 1;
      end
      cons_credits = cons_credits + (out_credit ? 1 : 0) - (out_valid ? 1 : 0);
      if (in_credit) begin
        tx_credits = tx_credits + 1;
        if (tx_credits > BEAT_DEPTH) abort_run("sender credits went above the beat queue depth");
      end
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > TIMEOUT_CYCLES) begin
      abort_run($sformatf("TIMEOUT: the run did not finish within %0d cycles", TIMEOUT_CYCLES));
    end
  end

  // returns one credit per packet, once with a long stall
  initial begin : consumer
    int delay;
    wait (reset_n === 1'b1);
    forever begin
      wait (owed > 0);
      if (!stalled && rx_count >= STALL_AFTER) begin
        stalled = 1'b1;
        delay   = STALL_CYCLES;
      end else begin
        delay = 1 + ($unsigned($random(seed)) % 6);
      end
      repeat (delay) @(posedge clk);
      #1 out_credit = 1'b1;
      owed = owed - 1;
      @(posedge clk);
      #1 out_credit = 1'b0;
    end
  end

  initial begin : main
    rx_types_pkg::count_t exp_drops;
    rx_types_pkg::count_t exp_frame_errs;
    int                   exp_delivered;
    reset_n    = 1'b0;
    in_beat    = '0;
    in_valid   = 1'b0;
    out_credit = 1'b0;
    exp_drops      = '0;
    exp_frame_errs = '0;
    exp_delivered  = 0;
    for (int i = 0; i < NUM_CASES; i++) begin
      if (CASES[i].outcome == DROPPED) exp_drops = exp_drops + 1'b1;
      if (CASES[i].outcome == FRAME_ERROR) exp_frame_errs = exp_frame_errs + 1'b1;
      if (CASES[i].outcome == DELIVERED) exp_delivered = exp_delivered + 1;
    end
    repeat (5) @(posedge clk);
    #1 reset_n = 1'b1;
    check_flag("out_valid after reset", out_valid, 1'b0);
    check_flag("in_credit after reset", in_credit, 1'b0);
    check_count("frame_errors after reset", frame_errors, '0);
    check_count("drops after reset", drops, '0);
    for (int i = 0; i < NUM_CASES; i++) begin
      send_case(CASES[i]);
    end
    @(posedge clk);
    #1 in_valid = 1'b0;
    wait (rx_count == exp_delivered && tx_credits == BEAT_DEPTH);  // all beats left the queue
    repeat (SETTLE_CYCLES) @(posedge clk);
    check_count("frame_errors", frame_errors, exp_frame_errs);
    check_count("drops", drops, exp_drops);
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

/* compile.f */
+incdir+bench
design/rx_types_pkg.sv
design/credit_queue.sv
design/packet_deframer.sv
design/dest_filter.sv
design/packet_rx_top.sv
bench/packet_rx_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the receive path with its testbench and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module packet_rx_tb \
  --Mdir obj_dir -o packet_rx_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/packet_rx_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -q "Simulation finished: PASS"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1
